// ==== flist.f ====
verilog/gamePkg.sv
verilog/paceTimer.sv
verilog/scoreKeeper.sv
verilog/gameSequencer.sv
verilog/gameControl.sv
test/gameControlTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for failure

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

rm -rf "$buildDir"
verilator --binary --timing -Wno-fatal --top-module gameControlTb \
	-f flist.f --Mdir "$buildDir" -o gameControlSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/gameControlSim" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
	echo "Simulator exited with status $runStatus"
	exit 1
fi

if grep -q "Simulation failed" "$logFile"; then
	exit 1
fi
exit 0

// ==== test/gameControlTb.sv ====
// Testbench for the car game control with reference model, output checker and watchdog
`default_nettype none

module gameControlTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam gamePkg::periodT bannerCycles = 28'd5;
	localparam gamePkg::periodT paceOne      = 28'd9;
	localparam gamePkg::periodT paceTwo      = 28'd6;
	localparam gamePkg::periodT paceThree    = 28'd3;
	localparam gamePkg::scoreT  scoreTwo     = 8'd4;
	localparam gamePkg::scoreT  scoreThree   = 8'd8;
	localparam gamePkg::scoreT  scoreFinal   = 8'd12;

	// Event kinds seen by the checker
	localparam int kindGo     = 0;
	localparam int kindBanner = 1;
	localparam int kindAdd    = 2;
	localparam int kindMove   = 3;
	localparam int kindFinish = 4;

	logic            SC_STATEMACHINE_GENERAL_CLOCK_50;
	logic            SC_STATEMACHINE_GENERAL_RESET_InHigh;
	logic            startButtonN;
	gamePkg::screenT screen;
	logic            carsAdd;
	logic            carsMove;
	gamePkg::scoreT  score;

	int              seed = 53;
	int              checkCount = 0;
	int              errorCount = 0;
	int              cycle = 0;
	int              lastCycle = 0;
	int              eventIdx = 0;
	bit              finishSeen = 1'b0;
	int              expectedGap = 0;
	int              expectedPts = 0;
	int              holdPts = 0;
	gamePkg::screenT expectedScreen = gamePkg::screenTitle;
	gamePkg::screenT holdScreen = gamePkg::screenTitle;
	gamePkg::screenT prevScreen = gamePkg::screenTitle;

	gameControl #(
		.bannerPeriod     (bannerCycles),
		.levelOnePeriod   (paceOne),
		.levelTwoPeriod   (paceTwo),
		.levelThreePeriod (paceThree),
		.levelTwoScore    (scoreTwo),
		.levelThreeScore  (scoreThree),
		.finalScore       (scoreFinal)
	) i_gameControl (
		.SC_STATEMACHINE_GENERAL_CLOCK_50     (SC_STATEMACHINE_GENERAL_CLOCK_50),
		.SC_STATEMACHINE_GENERAL_RESET_InHigh (SC_STATEMACHINE_GENERAL_RESET_InHigh),
		.startButtonN                         (startButtonN),
		.screen                               (screen),
		.carsAdd                              (carsAdd),
		.carsMove                             (carsMove),
		.score                                (score)
	);

	initial
	begin
		SC_STATEMACHINE_GENERAL_CLOCK_50 = 1'b0;
		forever #4 SC_STATEMACHINE_GENERAL_CLOCK_50 = ~SC_STATEMACHINE_GENERAL_CLOCK_50;
	end

	//============================================================
	// Reference model
	//============================================================
	// Level 1 to 3 while playing, 4 once the final score is reached
	function automatic int levelFor(input int points);
		if (points >= int'(scoreFinal))
			return 4;
		else if (points >= int'(scoreThree))
			return 3;
		else if (points >= int'(scoreTwo))
			return 2;
		return 1;
	endfunction

	function automatic int paceOf(input int level);
		if (level == 1)
			return int'(paceOne);
		else if (level == 2)
			return int'(paceTwo);
		return int'(paceThree);
	endfunction

	// Screen, points and cycles to the next event for event number idx of a game
	function automatic void expectedEvent(input int idx, output gamePkg::screenT scr,
		output int gap, output int pts);
		int kind;
		int level;
		int points;
		kind = kindGo;
		level = 1;
		points = 0;
		for (int k = 0; k < idx; k++)
		begin
			case (kind)
				kindGo: kind = kindBanner;
				kindBanner: kind = kindAdd;
				kindAdd: kind = kindMove;
				kindMove:
				begin
					points++;
					if (levelFor(points) > level)
					begin
						level = levelFor(points);
						kind = (level == 4) ? kindFinish : kindBanner;
					end
					else
						kind = kindAdd;
				end
				default: kind = kindFinish;
			endcase
		end
		pts = points;
		case (kind)
			kindGo:
			begin
				scr = gamePkg::screenGo;
				gap = int'(bannerCycles) + 1;
			end
			kindBanner:
			begin
				scr = (level == 1) ? gamePkg::screenLevel1 :
					(level == 2) ? gamePkg::screenLevel2 : gamePkg::screenLevel3;
				// Banner wait plus the speed state
				gap = int'(bannerCycles) + 2;
			end
			kindAdd:
			begin
				scr = gamePkg::screenPlayAdd;
				gap = paceOf(level) + 1;
			end
			kindMove:
			begin
				scr = gamePkg::screenPlay;
				gap = (levelFor(points + 1) > level) ? 2 : paceOf(level) + 1;
			end
			default:
			begin
				scr = gamePkg::screenFinish;
				gap = 0;
			end
		endcase
	endfunction

	function automatic int gameCycles();
		int total;
		int idx;
		int gap;
		int pts;
		gamePkg::screenT scr;
		total = 0;
		idx = 0;
		scr = gamePkg::screenGo;
		while (scr != gamePkg::screenFinish)
		begin
			expectedEvent(idx, scr, gap, pts);
			total += gap;
			idx++;
		end
		return total;
	endfunction

	task automatic checkValue(input int actual, input int expected, input string what);
		checkCount++;
		if (actual != expected)
		begin
			errorCount++;
			$display("ERR %0d ns: %s, got %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	//============================================================
	// Output checker sampling 2 ns after each rising edge
	//============================================================
	always
	begin : compareOutputs
		bit isEvent;
		int elapsed;
		@(posedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		#2;
		cycle++;
		isEvent = carsAdd || carsMove || ((screen != prevScreen) &&
			(screen != gamePkg::screenPlay) && (screen != gamePkg::screenTitle));
		elapsed = cycle - lastCycle;
		if (SC_STATEMACHINE_GENERAL_RESET_InHigh)
		begin
			eventIdx = 0;
			finishSeen = 1'b0;
			checkValue(int'(screen), int'(gamePkg::screenTitle), "screen in reset");
			checkValue(int'(score), 0, "score in reset");
			checkValue(int'(carsAdd || carsMove), 0, "car pulse in reset");
		end
		else if (eventIdx == 0 && !isEvent)
		begin
			checkValue(int'(screen), int'(gamePkg::screenTitle), "screen before start");
			checkValue(int'(score), 0, "score before start");
		end
		else
		begin
			if (eventIdx > 0 && expectedGap != 0 && elapsed == expectedGap)
				checkValue(int'(isEvent), 1, "event due at this cycle");
			if (isEvent)
			begin
				if (eventIdx > 0)
					checkValue(elapsed, expectedGap, "cycles since previous event");
				expectedEvent(eventIdx, expectedScreen, expectedGap, expectedPts);
				checkValue(int'(screen), int'(expectedScreen), "screen at event");
				checkValue(int'(carsAdd), int'(expectedScreen == gamePkg::screenPlayAdd),
					"carsAdd at event");
				checkValue(int'(carsMove), int'(expectedScreen == gamePkg::screenPlay),
					"carsMove at event");
				checkValue(int'(score), expectedPts, "score at event");
				holdScreen = (expectedScreen == gamePkg::screenPlayAdd) ?
					gamePkg::screenPlay : expectedScreen;
				// Score steps up in the cycle after a move
				holdPts = (expectedScreen == gamePkg::screenPlay) ? expectedPts + 1 : expectedPts;
				if (expectedScreen == gamePkg::screenFinish)
					finishSeen = 1'b1;
				lastCycle = cycle;
				eventIdx++;
			end
			else
			begin
				checkValue(int'(screen), int'(holdScreen), "screen between events");
				checkValue(int'(score), holdPts, "score between events");
			end
		end
		prevScreen = screen;
	end

	//============================================================
	// Stimulus
	//============================================================
	task automatic applyReset();
		@(negedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		SC_STATEMACHINE_GENERAL_RESET_InHigh = 1'b1;
		repeat (5) @(negedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		SC_STATEMACHINE_GENERAL_RESET_InHigh = 1'b0;
	endtask

	// Random idle time, then a press of random length
	task automatic pressStart();
		int idle;
		int hold;
		idle = 10 + int'($unsigned($random(seed)) % 30);
		hold = 1 + int'($unsigned($random(seed)) % 4);
		repeat (idle) @(negedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		startButtonN = 1'b0;
		repeat (hold) @(negedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		startButtonN = 1'b1;
	endtask

	initial
	begin
		SC_STATEMACHINE_GENERAL_RESET_InHigh = 1'b1;
		startButtonN = 1'b1;
		applyReset();
		pressStart();
		wait (finishSeen);
		// Finish screen ignores the button
		repeat (3) pressStart();
		applyReset();
		pressStart();
		// Break off the second game in level two
		wait (eventIdx >= 12);
		applyReset();
		pressStart();
		wait (finishSeen);
		repeat (20) @(negedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin : watchdog
		int limit;
		limit = 2 * (3 * gameCycles() + 600) + 200;
		repeat (limit) @(posedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		$display("Timeout: the run did not end within %0d clock cycles", limit);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/gameControl.sv ====
// Top level of the car game control, pace timer, score keeper and sequencer
`default_nettype none

module gameControl #(
	parameter gamePkg::periodT bannerPeriod     = gamePkg::defaultBannerPeriod,
	parameter gamePkg::periodT levelOnePeriod   = gamePkg::defaultLevelOnePeriod,
	parameter gamePkg::periodT levelTwoPeriod   = gamePkg::defaultLevelTwoPeriod,
	parameter gamePkg::periodT levelThreePeriod = gamePkg::defaultLevelThreePeriod,
	parameter gamePkg::scoreT  levelTwoScore    = gamePkg::defaultLevelTwoScore,
	parameter gamePkg::scoreT  levelThreeScore  = gamePkg::defaultLevelThreeScore,
	parameter gamePkg::scoreT  finalScore       = gamePkg::defaultFinalScore
)(
	input  logic            SC_STATEMACHINE_GENERAL_CLOCK_50,
	input  logic            SC_STATEMACHINE_GENERAL_RESET_InHigh,
	input  logic            startButtonN,
	output gamePkg::screenT screen,
	output logic            carsAdd,
	output logic            carsMove,
	output gamePkg::scoreT  score
);

	//============================================================
	// Internal strobes and status
	//============================================================
	logic            timerLoad;
	gamePkg::periodT timerPeriod;
	logic            tick;
	logic            scoreClear;
	gamePkg::levelT  reachedLevel;

	paceTimer #(
		.periodWidth (gamePkg::periodWidth)
	) i_paceTimer (
		.SC_STATEMACHINE_GENERAL_CLOCK_50     (SC_STATEMACHINE_GENERAL_CLOCK_50),
		.SC_STATEMACHINE_GENERAL_RESET_InHigh (SC_STATEMACHINE_GENERAL_RESET_InHigh),
		.timerLoad                            (timerLoad),
		.timerPeriod                          (timerPeriod),
		.tick                                 (tick)
	);

	// Points come from the move strobe
	scoreKeeper #(
		.levelTwoScore   (levelTwoScore),
		.levelThreeScore (levelThreeScore),
		.finalScore      (finalScore)
	) i_scoreKeeper (
		.SC_STATEMACHINE_GENERAL_CLOCK_50     (SC_STATEMACHINE_GENERAL_CLOCK_50),
		.SC_STATEMACHINE_GENERAL_RESET_InHigh (SC_STATEMACHINE_GENERAL_RESET_InHigh),
		.scoreClear                           (scoreClear),
		.carsMove                             (carsMove),
		.score                                (score),
		.reachedLevel                         (reachedLevel)
	);

	gameSequencer #(
		.bannerPeriod     (bannerPeriod),
		.levelOnePeriod   (levelOnePeriod),
		.levelTwoPeriod   (levelTwoPeriod),
		.levelThreePeriod (levelThreePeriod)
	) i_gameSequencer (
		.SC_STATEMACHINE_GENERAL_CLOCK_50     (SC_STATEMACHINE_GENERAL_CLOCK_50),
		.SC_STATEMACHINE_GENERAL_RESET_InHigh (SC_STATEMACHINE_GENERAL_RESET_InHigh),
		.startButtonN                         (startButtonN),
		.tick                                 (tick),
		.reachedLevel                         (reachedLevel),
		.timerLoad                            (timerLoad),
		.timerPeriod                          (timerPeriod),
		.scoreClear                           (scoreClear),
		.carsAdd                              (carsAdd),
		.carsMove                             (carsMove),
		.screen                               (screen)
	);

endmodule

`default_nettype wire

// ==== verilog/gamePkg.sv ====
// Width types, screen codes, level codes and default timing for the car game control
`default_nettype none

package gamePkg;

	//============================================================
	// Widths
	//============================================================
	localparam int periodWidth = 28;

	// Pace or banner duration in clock cycles
	typedef logic [periodWidth-1:0] periodT;
	// Points in the current game
	typedef logic [7:0] scoreT;
	// Game level, 3 is the finished game
	typedef logic [1:0] levelT;
	// Display screen code
	typedef logic [3:0] screenT;

	//============================================================
	// Screen codes
	//============================================================
	localparam screenT screenTitle   = 4'd0;
	localparam screenT screenGo      = 4'd1;
	localparam screenT screenLevel1  = 4'd2;
	localparam screenT screenLevel2  = 4'd3;
	localparam screenT screenLevel3  = 4'd4;
	localparam screenT screenFinish  = 4'd7;
	localparam screenT screenPlay    = 4'd8;
	localparam screenT screenPlayAdd = 4'd9;

	// Level codes, ordered so a larger code is a later level
	localparam levelT levelOne   = 2'd0;
	localparam levelT levelTwo   = 2'd1;
	localparam levelT levelThree = 2'd2;
	localparam levelT levelDone  = 2'd3;

	//============================================================
	// Default timing and thresholds, 50 MHz clock
	//============================================================
	localparam periodT defaultBannerPeriod     = 28'd150_000_000;
	localparam periodT defaultLevelOnePeriod   = 28'd50_000_000;
	localparam periodT defaultLevelTwoPeriod   = 28'd25_000_000;
	localparam periodT defaultLevelThreePeriod = 28'd15_000_000;

	localparam scoreT defaultLevelTwoScore   = 8'd23;
	localparam scoreT defaultLevelThreeScore = 8'd43;
	localparam scoreT defaultFinalScore      = 8'd68;

endpackage

`default_nettype wire

// ==== verilog/gameSequencer.sv ====
// Game FSM that picks the screen, loads the pace timer and strobes the cars
`default_nettype none

module gameSequencer #(
	parameter gamePkg::periodT bannerPeriod      = gamePkg::defaultBannerPeriod,
	parameter gamePkg::periodT levelOnePeriod    = gamePkg::defaultLevelOnePeriod,
	parameter gamePkg::periodT levelTwoPeriod    = gamePkg::defaultLevelTwoPeriod,
	parameter gamePkg::periodT levelThreePeriod  = gamePkg::defaultLevelThreePeriod
)(
	input  logic            SC_STATEMACHINE_GENERAL_CLOCK_50,
	input  logic            SC_STATEMACHINE_GENERAL_RESET_InHigh,
	input  logic            startButtonN,
	input  logic            tick,
	input  gamePkg::levelT  reachedLevel,
	output logic            timerLoad,
	output gamePkg::periodT timerPeriod,
	output logic            scoreClear,
	output logic            carsAdd,
	output logic            carsMove,
	output gamePkg::screenT screen
);

	typedef enum logic [3:0] {
		stateReset,
		stateTitle,
		stateGo,
		stateGoWait,
		stateBanner,
		stateBannerWait,
		stateSpeed,
		stateAdd,
		stateAddWait,
		stateMove,
		stateMoveWait,
		stateFinish
	} stateT;

	stateT           state;
	stateT           stateNext;
	gamePkg::levelT  currentLevel;
	gamePkg::levelT  levelNext;
	// Pace and banner screen of the current level
	gamePkg::periodT pace;
	gamePkg::screenT bannerScreen;

	always_comb
	begin
		case (currentLevel)
			gamePkg::levelTwo:
			begin
				pace         = levelTwoPeriod;
				bannerScreen = gamePkg::screenLevel2;
			end
			gamePkg::levelThree, gamePkg::levelDone:
			begin
				pace         = levelThreePeriod;
				bannerScreen = gamePkg::screenLevel3;
			end
			default:
			begin
				pace         = levelOnePeriod;
				bannerScreen = gamePkg::screenLevel1;
			end
		endcase
	end

	//============================================================
	// Next state
	//============================================================
	always_comb
	begin
		stateNext = state;
		levelNext = currentLevel;
		case (state)
			stateReset: stateNext = stateTitle;
			stateTitle:
			begin
				levelNext = gamePkg::levelOne;
				if (!startButtonN)
					stateNext = stateGo;
			end
			stateGo: stateNext = stateGoWait;
			stateGoWait:
			begin
				if (tick)
					stateNext = stateBanner;
			end
			stateBanner: stateNext = stateBannerWait;
			stateBannerWait:
			begin
				if (tick)
					stateNext = stateSpeed;
			end
			stateSpeed: stateNext = stateAdd;
			stateAdd: stateNext = stateAddWait;
			stateMove: stateNext = stateMoveWait;
			stateAddWait, stateMoveWait:
			begin
				// A new level wins over the pace tick
				if (reachedLevel > currentLevel)
				begin
					levelNext = reachedLevel;
					if (reachedLevel == gamePkg::levelDone)
						stateNext = stateFinish;
					else
						stateNext = stateBanner;
				end
				else if (tick)
				begin
					if (state == stateAddWait)
						stateNext = stateMove;
					else
						stateNext = stateAdd;
				end
			end
			// Held until reset
			stateFinish: stateNext = stateFinish;
			default: stateNext = stateReset;
		endcase
	end

	always_ff @(posedge SC_STATEMACHINE_GENERAL_CLOCK_50, posedge SC_STATEMACHINE_GENERAL_RESET_InHigh)
	begin
		if (SC_STATEMACHINE_GENERAL_RESET_InHigh)
		begin
			state        <= stateReset;
			currentLevel <= gamePkg::levelOne;
		end
		else
		begin
			state        <= stateNext;
			currentLevel <= levelNext;
		end
	end

	//============================================================
	// Outputs
	//============================================================
	always_comb
	begin
		timerLoad   = 1'b0;
		timerPeriod = pace;
		scoreClear  = 1'b0;
		carsAdd     = 1'b0;
		carsMove    = 1'b0;
		screen      = gamePkg::screenPlay;
		case (state)
			stateReset: screen = gamePkg::screenTitle;
			stateTitle:
			begin
				scoreClear = 1'b1;
				screen     = gamePkg::screenTitle;
			end
			stateGo:
			begin
				timerLoad   = 1'b1;
				timerPeriod = bannerPeriod;
				screen      = gamePkg::screenGo;
			end
			stateGoWait: screen = gamePkg::screenGo;
			stateBanner:
			begin
				timerLoad   = 1'b1;
				timerPeriod = bannerPeriod;
				screen      = bannerScreen;
			end
			stateBannerWait: screen = bannerScreen;
			stateSpeed:
			begin
				timerLoad = 1'b1;
				screen    = bannerScreen;
			end
			stateAdd:
			begin
				timerLoad = 1'b1;
				carsAdd   = 1'b1;
				screen    = gamePkg::screenPlayAdd;
			end
			stateMove:
			begin
				timerLoad = 1'b1;
				carsMove  = 1'b1;
			end
			stateAddWait, stateMoveWait: screen = gamePkg::screenPlay;
			stateFinish: screen = gamePkg::screenFinish;
			default: screen = gamePkg::screenTitle;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/paceTimer.sv ====
// Loadable down-counter that issues a single tick when the loaded period expires
`default_nettype none

module paceTimer #(
	parameter int periodWidth = gamePkg::periodWidth
)(
	input  logic            SC_STATEMACHINE_GENERAL_CLOCK_50,
	input  logic            SC_STATEMACHINE_GENERAL_RESET_InHigh,
	input  logic            timerLoad,
	input  gamePkg::periodT timerPeriod,
	output logic            tick
);

	// Cycles left until the tick, counts down to zero
	logic [periodWidth-1:0] remaining;
	// Set by a load, cleared after the tick
	logic                   running;

	//============================================================
	// Counter
	//============================================================
	always_ff @(posedge SC_STATEMACHINE_GENERAL_CLOCK_50, posedge SC_STATEMACHINE_GENERAL_RESET_InHigh)
	begin
		if (SC_STATEMACHINE_GENERAL_RESET_InHigh)
		begin
			remaining <= '0;
			running   <= 1'b0;
		end
		else if (timerLoad)
		begin
			// A load restarts the count even mid-period
			remaining <= periodWidth'(timerPeriod - 1'b1);
			running   <= 1'b1;
		end
		else if (running)
		begin
			if (remaining == '0)
				running <= 1'b0;
			else
				remaining <= remaining - 1'b1;
		end
	end

	// Tick lands timerPeriod cycles after the load cycle
	assign tick = running && (remaining == '0);

endmodule

`default_nettype wire

// ==== verilog/scoreKeeper.sv ====
// Saturating point counter with threshold decode to the level reached
`default_nettype none

module scoreKeeper #(
	parameter gamePkg::scoreT levelTwoScore   = gamePkg::defaultLevelTwoScore,
	parameter gamePkg::scoreT levelThreeScore = gamePkg::defaultLevelThreeScore,
	parameter gamePkg::scoreT finalScore      = gamePkg::defaultFinalScore
)(
	input  logic           SC_STATEMACHINE_GENERAL_CLOCK_50,
	input  logic           SC_STATEMACHINE_GENERAL_RESET_InHigh,
	input  logic           scoreClear,
	input  logic           carsMove,
	output gamePkg::scoreT score,
	output gamePkg::levelT reachedLevel
);

	gamePkg::scoreT scoreNext;

	// Level for a given number of points
	function automatic gamePkg::levelT levelOf(input gamePkg::scoreT points);
		if (points >= finalScore)
			return gamePkg::levelDone;
		else if (points >= levelThreeScore)
			return gamePkg::levelThree;
		else if (points >= levelTwoScore)
			return gamePkg::levelTwo;
		else
			return gamePkg::levelOne;
	endfunction

	//============================================================
	// Score update
	//============================================================
	always_comb
	begin
		scoreNext = score;
		if (scoreClear)
			scoreNext = '0;
		else if (carsMove && (score != '1))
			scoreNext = score + 1'b1;
	end

	// Level decoded from the new value so both change in the same cycle
	always_ff @(posedge SC_STATEMACHINE_GENERAL_CLOCK_50, posedge SC_STATEMACHINE_GENERAL_RESET_InHigh)
	begin
		if (SC_STATEMACHINE_GENERAL_RESET_InHigh)
		begin
			score        <= '0;
			reachedLevel <= gamePkg::levelOne;
		end
		else
		begin
			score        <= scoreNext;
			reachedLevel <= levelOf(scoreNext);
		end
	end

endmodule

`default_nettype wire
